//--- rtl/snappy_pkg.sv
`default_nettype none

package snappy_pkg;

    localparam int WORD_W     = 64;
    localparam int WORD_BYTES = 8;
    localparam int BYTE_PTR_W = 3;
    localparam int WIN_ADDR_W = 16;
    localparam int WIN_DEPTH  = 65536;
    localparam int LEN_W      = 32;

    // element kind, low two bits of every tag byte.
    localparam logic [1:0] TAG_LITERAL = 2'b00;
    localparam logic [1:0] TAG_COPY1   = 2'b01;
    localparam logic [1:0] TAG_COPY2   = 2'b10;

    localparam logic [5:0] LIT_LEN_EXT1 = 6'd60; // one length byte follows.
    localparam logic [5:0] LIT_LEN_EXT2 = 6'd61; // two length bytes follow.

    localparam int COPY1_LEN_BIAS = 4;

    // controller FSM states.
    localparam logic [2:0] ST_PRE   = 3'd0;
    localparam logic [2:0] ST_TAG   = 3'd1;
    localparam logic [2:0] ST_LEN   = 3'd2;
    localparam logic [2:0] ST_OFF   = 3'd3;
    localparam logic [2:0] ST_LIT   = 3'd4;
    localparam logic [2:0] ST_CP_RD = 3'd5;
    localparam logic [2:0] ST_CP_WR = 3'd6;
    localparam logic [2:0] ST_END   = 3'd7;

    // one tag byte, seen as literal/copy2 or as copy1.
    typedef union packed {
        struct packed {
            logic [5:0] len_code;
            logic [1:0] kind;
        } lit;
        struct packed {
            logic [2:0] off_hi;
            logic [2:0] len;
            logic [1:0] kind;
        } cp1;
    } snappy_tag_t;

endpackage

`default_nettype wire

//--- rtl/input_byte_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module input_byte_feeder import snappy_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [WORD_W-1:0] in_data,
    input  wire               in_valid,
    output logic              in_ready,
    output logic [7:0]        byte_data,
    output logic              byte_valid,
    input  wire               byte_take,
    input  wire               word_drop
);

    localparam logic [BYTE_PTR_W-1:0] PTR_LAST = BYTE_PTR_W'(WORD_BYTES - 1);

    logic [WORD_W-1:0]     word_q;
    logic [BYTE_PTR_W-1:0] ptr_q;
    logic                  full_q;
    logic                  load;
    logic                  empty_now;

    assign load       = in_ready && in_valid;
    assign empty_now  = full_q && (word_drop || (byte_take && ptr_q == PTR_LAST));
    assign byte_valid = full_q;
    assign byte_data  = word_q[{ptr_q, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q   <= 1'b0;
            in_ready <= 1'b0;
        end else if (load) begin
            full_q   <= 1'b1;
            in_ready <= 1'b0;
        end else if (empty_now) begin
            full_q   <= 1'b0;
            in_ready <= 1'b1; // next word accepted in the following cycle.
        end else if (!full_q) begin
            in_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= in_data;
            ptr_q  <= '0;
        end else if (byte_take) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/history_window.sv
`timescale 1ns/1ps
`default_nettype none

module history_window import snappy_pkg::*; (
    input  wire                  clk,
    input  wire                  blk_start,
    input  wire                  wr_en,
    input  wire [7:0]            wr_byte,
    input  wire                  rd_start,
    input  wire [WIN_ADDR_W-1:0] rd_offset,
    input  wire                  rd_next,
    output logic [7:0]           rd_byte
);

    logic [7:0]            mem [WIN_DEPTH];
    logic [WIN_ADDR_W-1:0] wr_ptr;
    logic [WIN_ADDR_W-1:0] rd_ptr;
    logic [WIN_ADDR_W-1:0] rd_addr;

    // back-reference start, wraps at 16 bits.
    assign rd_addr = rd_start ? wr_ptr - rd_offset : rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (blk_start) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            mem[wr_ptr] <= wr_byte;
            wr_ptr      <= wr_ptr + 1'b1;
        end
        if (rd_start || rd_next) begin
            rd_ptr  <= rd_addr;
            rd_byte <= mem[rd_addr]; // held until the next read.
        end
    end

endmodule

`default_nettype wire

//--- rtl/output_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module output_word_packer import snappy_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               pk_en,
    input  wire  [7:0]        pk_byte,
    input  wire               pk_last,
    output logic              pk_ready,
    output logic [WORD_W-1:0] out_data,
    output logic              out_valid,
    output logic              out_last,
    input  wire               out_ready
);

    localparam logic [BYTE_PTR_W-1:0] FILL_LAST = BYTE_PTR_W'(WORD_BYTES - 1);

    logic [BYTE_PTR_W-1:0] fill_q;

    // no new bytes while a word waits for the sink.
    assign pk_ready = !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_data  <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            fill_q    <= '0;
        end else if (out_valid) begin
            if (out_ready) begin
                out_data  <= '0; // upper bytes of a short word stay zero.
                out_valid <= 1'b0;
                out_last  <= 1'b0;
                fill_q    <= '0;
            end
        end else if (pk_en) begin
            out_data[{fill_q, 3'b000} +: 8] <= pk_byte;
            fill_q <= fill_q + 1'b1;
            if (pk_last || fill_q == FILL_LAST) begin
                out_valid <= 1'b1;
                out_last  <= pk_last;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/snappy_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module snappy_ctrl import snappy_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire  [7:0]            byte_data,
    input  wire                   byte_valid,
    output logic                  byte_take,
    output logic                  word_drop,
    output logic                  wr_en,
    output logic [7:0]            wr_byte,
    output logic                  blk_start,
    output logic                  rd_start,
    output logic [WIN_ADDR_W-1:0] rd_offset,
    output logic                  rd_next,
    input  wire  [7:0]            rd_byte,
    output logic                  pk_en,
    output logic [7:0]            pk_byte,
    output logic                  pk_last,
    input  wire                   pk_ready
);

    logic [2:0]            state_q;
    logic [LEN_W-1:0]      blk_len_q;   // bytes left in the block.
    logic [LEN_W-1:0]      elem_len_q;  // bytes left in the element.
    logic [WIN_ADDR_W-1:0] off_q;
    logic [4:0]            pre_sh_q;
    logic                  more_q;      // another length/offset byte follows.
    logic                  hi_q;        // current field byte is the high one.
    snappy_tag_t           tag;
    logic [LEN_W-1:0]      fld;
    logic                  last_byte;

    assign tag       = byte_data;
    assign fld       = LEN_W'(byte_data) << {hi_q, 3'b000};
    assign last_byte = (blk_len_q == LEN_W'(1));

    assign rd_offset = off_q | fld[WIN_ADDR_W-1:0];
    assign blk_start = (state_q == ST_PRE);
    assign word_drop = (state_q == ST_END);
    assign wr_en     = pk_en;
    assign wr_byte   = pk_byte;
    assign pk_last   = pk_en && last_byte;

    always_comb begin
        byte_take = 1'b0;
        pk_en     = 1'b0;
        pk_byte   = byte_data;
        rd_start  = 1'b0;
        rd_next   = 1'b0;
        case (state_q)
            ST_PRE, ST_TAG, ST_LEN: begin
                byte_take = byte_valid;
            end
            ST_OFF: begin
                byte_take = byte_valid;
                rd_start  = byte_valid && !more_q; // final offset byte.
            end
            ST_LIT: begin
                byte_take = byte_valid && pk_ready;
                pk_en     = byte_valid && pk_ready;
            end
            ST_CP_RD: begin
                rd_next = 1'b1;
            end
            ST_CP_WR: begin
                pk_en   = pk_ready;
                pk_byte = rd_byte;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_PRE;
            blk_len_q  <= '0;
            elem_len_q <= '0;
            off_q      <= '0;
            pre_sh_q   <= '0;
            more_q     <= 1'b0;
            hi_q       <= 1'b0;
        end else begin
            case (state_q)
                ST_PRE: begin
                    if (byte_valid) begin
                        blk_len_q <= blk_len_q | (LEN_W'(byte_data[6:0]) << pre_sh_q);
                        pre_sh_q  <= pre_sh_q + 5'd7;
                        if (!byte_data[7]) begin
                            state_q <= ST_TAG;
                        end
                    end
                end
                ST_TAG: begin
                    if (byte_valid) begin
                        hi_q <= 1'b0;
                        case (tag.lit.kind)
                            TAG_LITERAL: begin
                                more_q <= (tag.lit.len_code == LIT_LEN_EXT2);
                                if (tag.lit.len_code >= LIT_LEN_EXT1) begin
                                    elem_len_q <= '0;
                                    state_q    <= ST_LEN;
                                end else begin
                                    elem_len_q <= LEN_W'(tag.lit.len_code) + 1'b1;
                                    state_q    <= ST_LIT;
                                end
                            end
                            TAG_COPY1: begin
                                elem_len_q <= LEN_W'(tag.cp1.len) + COPY1_LEN_BIAS;
                                off_q      <= {5'b0, tag.cp1.off_hi, 8'h00};
                                more_q     <= 1'b0;
                                state_q    <= ST_OFF;
                            end
                            TAG_COPY2: begin
                                elem_len_q <= LEN_W'(tag.lit.len_code) + 1'b1;
                                off_q      <= '0;
                                more_q     <= 1'b1;
                                state_q    <= ST_OFF;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                ST_LEN: begin
                    if (byte_valid) begin
                        if (more_q) begin
                            elem_len_q <= fld;
                            more_q     <= 1'b0;
                            hi_q       <= 1'b1;
                        end else begin
                            elem_len_q <= (elem_len_q | fld) + 1'b1; // stored as length - 1.
                            state_q    <= ST_LIT;
                        end
                    end
                end
                ST_OFF: begin
                    if (byte_valid) begin
                        if (more_q) begin
                            off_q  <= rd_offset;
                            more_q <= 1'b0;
                            hi_q   <= 1'b1;
                        end else begin
                            state_q <= ST_CP_WR;
                        end
                    end
                end
                ST_LIT, ST_CP_WR: begin
                    if (pk_en) begin
                        blk_len_q  <= blk_len_q - 1'b1;
                        elem_len_q <= elem_len_q - 1'b1;
                        if (last_byte) begin
                            state_q <= ST_END;
                        end else if (elem_len_q == LEN_W'(1)) begin
                            state_q <= ST_TAG;
                        end else if (state_q == ST_CP_WR) begin
                            state_q <= ST_CP_RD;
                        end
                    end
                end
                ST_CP_RD: begin
                    state_q <= ST_CP_WR;
                end
                default: begin
                    blk_len_q <= '0; // ST_END, drop the rest of the word.
                    pre_sh_q  <= '0;
                    state_q   <= ST_PRE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/snappy_decompressor.sv
`timescale 1ns/1ps
`default_nettype none

module snappy_decompressor import snappy_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [WORD_W-1:0] in_data,
    input  wire               in_valid,
    output logic              in_ready,
    output logic [WORD_W-1:0] out_data,
    output logic              out_valid,
    output logic              out_last,
    input  wire               out_ready
);

    logic [7:0]            byte_data;
    logic                  byte_valid;
    logic                  byte_take;
    logic                  word_drop;
    logic                  wr_en;
    logic [7:0]            wr_byte;
    logic                  blk_start;
    logic                  rd_start;
    logic [WIN_ADDR_W-1:0] rd_offset;
    logic                  rd_next;
    logic [7:0]            rd_byte;
    logic                  pk_en;
    logic [7:0]            pk_byte;
    logic                  pk_last;
    logic                  pk_ready;

    input_byte_feeder input_byte_feeder_i (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_take  (byte_take),
        .word_drop  (word_drop)
    );

    snappy_ctrl snappy_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_take  (byte_take),
        .word_drop  (word_drop),
        .wr_en      (wr_en),
        .wr_byte    (wr_byte),
        .blk_start  (blk_start),
        .rd_start   (rd_start),
        .rd_offset  (rd_offset),
        .rd_next    (rd_next),
        .rd_byte    (rd_byte),
        .pk_en      (pk_en),
        .pk_byte    (pk_byte),
        .pk_last    (pk_last),
        .pk_ready   (pk_ready)
    );

    history_window history_window_i (
        .clk       (clk),
        .blk_start (blk_start),
        .wr_en     (wr_en),
        .wr_byte   (wr_byte),
        .rd_start  (rd_start),
        .rd_offset (rd_offset),
        .rd_next   (rd_next),
        .rd_byte   (rd_byte)
    );

    output_word_packer output_word_packer_i (
        .clk       (clk),
        .rst       (rst),
        .pk_en     (pk_en),
        .pk_byte   (pk_byte),
        .pk_last   (pk_last),
        .pk_ready  (pk_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/snappy_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module snappy_assertions (
    input wire        clk,
    input wire        rst,
    input wire        in_ready,
    input wire [63:0] out_data,
    input wire        out_valid,
    input wire        out_last,
    input wire        out_ready
);

    // a presented word holds until the sink takes it.
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
        else $error("out_data or out_last changed while stalled");

    assert property (@(posedge clk) disable iff (rst) out_last |-> out_valid)
        else $error("out_last high without out_valid");

    assert property (@(posedge clk) $fell(rst) |-> !out_valid && !in_ready)
        else $error("out_valid or in_ready high in the first cycle after reset");

endmodule

bind snappy_decompressor snappy_assertions snappy_assertions_i (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
);

`default_nettype wire

//--- bench/tb_snappy_decompressor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snappy_decompressor;

    localparam int TIMEOUT = 2000;  // cycles per wait.
    localparam int N_TESTS = 11;
    localparam int K_LIT   = 0;
    localparam int K_COPY1 = 1;     // 1-byte literal, then copy at offset 1.
    localparam int K_COPY2 = 2;     // 300-byte literal, then copy at offset 300.

    // per test: element mix, block length, expected output words, random stalls.
    localparam int T_KIND  [N_TESTS] = '{K_LIT, K_LIT, K_LIT, K_LIT, K_COPY1, K_COPY2,
                                         K_LIT, K_LIT, K_LIT, K_COPY1, K_COPY2};
    localparam int T_LEN   [N_TESTS] = '{5, 20, 100, 300, 11, 320, 20, 100, 300, 11, 320};
    localparam int T_WORDS [N_TESTS] = '{1, 3, 13, 38, 2, 40, 3, 13, 38, 2, 40};
    localparam bit T_STALL [N_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1};

    logic        clk;
    logic        rst;
    logic [63:0] in_data;
    logic        in_valid;
    logic        in_ready;
    logic [63:0] out_data;
    logic        out_valid;
    logic        out_last;
    logic        out_ready;

    logic [7:0]  comp_q[$];
    logic [7:0]  exp_q[$];
    logic        stall_mode;
    logic        hung;
    int          errors;
    int          failed;
    logic        was_stalled;
    logic [63:0] held_data;
    logic        held_last;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    snappy_decompressor snappy_decompressor_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    function automatic logic [7:0] pattern(input int idx, input int pos);
        return 8'(pos * 37 + (pos >> 8) * 11 + idx * 5 + 3);
    endfunction

    task automatic push_varint(input int value);
        int v;
        v = value;
        while (v >= 128) begin
            comp_q.push_back(8'(v) | 8'h80);
            v = v >> 7;
        end
        comp_q.push_back(8'(v));
    endtask

    task automatic push_literal(input int idx, input int n);
        int i;
        int code;
        code = n - 1;
        if (code < 60) begin
            comp_q.push_back({6'(code), 2'b00});
        end else if (code < 256) begin
            comp_q.push_back(8'hf0); // code 60.
            comp_q.push_back(8'(code));
        end else begin
            comp_q.push_back(8'hf4); // code 61.
            comp_q.push_back(8'(code));
            comp_q.push_back(8'(code >> 8));
        end
        for (i = 0; i < n; i++) begin
            comp_q.push_back(pattern(idx, i));
            exp_q.push_back(pattern(idx, i));
        end
    endtask

    task automatic push_copy(input int off, input int len);
        int k;
        if (off < 2048 && len >= 4 && len <= 11) begin
            comp_q.push_back({3'(off >> 8), 3'(len - 4), 2'b01});
            comp_q.push_back(8'(off));
        end else begin
            comp_q.push_back({6'(len - 1), 2'b10});
            comp_q.push_back(8'(off));
            comp_q.push_back(8'(off >> 8));
        end
        // byte by byte, so an overlapping copy repeats what it just wrote.
        for (k = 0; k < len; k++) begin
            exp_q.push_back(exp_q[exp_q.size() - off]);
        end
    endtask

    task automatic build_block(input int idx);
        comp_q.delete();
        exp_q.delete();
        push_varint(T_LEN[idx]);
        if (T_KIND[idx] == K_COPY1) begin
            push_literal(idx, 1);
            push_copy(1, T_LEN[idx] - 1);
        end else if (T_KIND[idx] == K_COPY2) begin
            push_literal(idx, 300);
            push_copy(300, T_LEN[idx] - 300);
        end else begin
            push_literal(idx, T_LEN[idx]);
        end
    endtask

    task automatic send_block(input logic gaps);
        int          w;
        int          b;
        int          t;
        logic [63:0] word;
        for (w = 0; w < (comp_q.size() + 7) / 8; w++) begin
            word = '0;
            for (b = 0; b < 8; b++) begin
                if (w * 8 + b < comp_q.size()) begin
                    word[b * 8 +: 8] = comp_q[w * 8 + b];
                end
            end
            if (gaps) begin
                repeat ($urandom % 4) @(posedge clk);
            end
            @(posedge clk);
            in_data  <= word;
            in_valid <= 1'b1;
            t = 0;
            @(negedge clk);
            while (!in_ready) begin
                if (t == TIMEOUT) begin
                    $display("input word %0d was not accepted within %0d cycles", w, TIMEOUT);
                    hung = 1'b1;
                    return;
                end
                t++;
                @(negedge clk);
            end
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic recv_block(input int idx);
        int          w;
        int          b;
        int          t;
        logic [63:0] exp_word;
        for (w = 0; w < T_WORDS[idx]; w++) begin
            t = 0;
            @(negedge clk);
            while (!(out_valid && out_ready)) begin
                if (t == TIMEOUT) begin
                    $display("output word %0d did not arrive within %0d cycles", w, TIMEOUT);
                    hung = 1'b1;
                    return;
                end
                t++;
                @(negedge clk);
            end
            exp_word = '0;
            for (b = 0; b < 8; b++) begin
                if (w * 8 + b < exp_q.size()) begin
                    exp_word[b * 8 +: 8] = exp_q[w * 8 + b];
                end
            end
            if (out_data !== exp_word) begin
                $display("ERR out_data word %0d got %h expected %h", w, out_data, exp_word);
                errors++;
            end
            if (out_last !== (w == T_WORDS[idx] - 1)) begin
                $display("ERR out_last word %0d got %h expected %h", w, out_last,
                         w == T_WORDS[idx] - 1);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        int err_before;
        err_before = errors;
        build_block(idx);
        stall_mode = T_STALL[idx];
        fork
            send_block(T_STALL[idx]);
            recv_block(idx);
        join
        if (errors == err_before && !hung) begin
            $display("test %0d: kind %0d, %0d bytes, stalls %0d: ok",
                     idx, T_KIND[idx], T_LEN[idx], T_STALL[idx]);
        end else begin
            $display("test %0d: kind %0d, %0d bytes, stalls %0d: failed",
                     idx, T_KIND[idx], T_LEN[idx], T_STALL[idx]);
            failed++;
        end
    endtask

    always @(posedge clk) begin
        out_ready <= stall_mode ? (($urandom % 4) != 0) : 1'b1;
    end

    // a stalled word must still be there, unchanged, one cycle later.
    always @(negedge clk) begin
        if (!rst && was_stalled) begin
            if (!out_valid) begin
                $display("ERR out_valid got %h expected %h while stalled", out_valid, 1'b1);
                errors++;
            end
            if (out_data !== held_data) begin
                $display("ERR out_data got %h expected %h while stalled", out_data, held_data);
                errors++;
            end
            if (out_last !== held_last) begin
                $display("ERR out_last got %h expected %h while stalled", out_last, held_last);
                errors++;
            end
        end
        was_stalled = out_valid && !out_ready;
        held_data   = out_data;
        held_last   = out_last;
    end

    initial begin
        int i;
        int t;
        in_data     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        stall_mode  = 1'b0;
        hung        = 1'b0;
        errors      = 0;
        failed      = 0;
        was_stalled = 1'b0;
        held_data   = '0;
        held_last   = 1'b0;
        void'($urandom(32'ha400));
        t = 0;
        while (rst !== 1'b0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            hung = 1'b1;
        end
        @(posedge clk);
        for (i = 0; i < N_TESTS; i++) begin
            if (!hung) begin
                run_test(i);
            end
        end
        $display("tests: %0d, failed: %0d, errors: %0d, timeout: %0d",
                 N_TESTS, failed, errors, hung);
        if (errors == 0 && failed == 0 && !hung) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/snappy_pkg.sv
rtl/input_byte_feeder.sv
rtl/history_window.sv
rtl/output_word_packer.sv
rtl/snappy_ctrl.sv
rtl/snappy_decompressor.sv
bench/tb_clock_gen.sv
bench/snappy_assertions.sv
bench/tb_snappy_decompressor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Snappy decompressor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_snappy_decompressor -f files.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
